/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tbRouterOutputPort
FILELIST  = src.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)

SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) hdl/noc_consts.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Vector file paths are relative to the project root
run: $(SIM) verif/arb_vectors.txt
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/nocArbPkg.sv */
`include "noc_consts.svh"

package nocArbPkg;

  typedef logic [`NOC_FLIT_ID_W-1:0] flitIdT;
  typedef logic [`NOC_LENGTH_W-1:0]  lengthT;
  typedef logic [`NOC_DATA_W-1:0]    flitDataT;

  // Bit 0 is Local, then North, East, West and South
  typedef logic [`NOC_NUM_PORTS-1:0] portMaskT;

  typedef struct packed
  {
    logic     req;
    flitIdT   flitId;
    lengthT   length;
    flitDataT data;
  } portInT;

  typedef portInT [`NOC_NUM_PORTS-1:0] portInArrT;

  typedef struct packed
  {
    logic     valid;
    flitDataT data;
  } outFlitT;

  // One-hot, grant bits sit above the IDLE bit
  typedef enum logic [`NOC_NUM_PORTS:0]
  {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbStateT;

endpackage

/* hdl/noc_consts.svh */
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Local, North, East, West and South
`define NOC_NUM_PORTS 5

// Field widths of one input port
`define NOC_FLIT_ID_W 3
`define NOC_LENGTH_W  12
`define NOC_DATA_W    16

// Flit id that marks a header flit
`define NOC_HEAD_ID   1

`endif

/* hdl/outputArbiter.sv */
`include "noc_consts.svh"

module outputArbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  nocArbPkg::portInArrT inPorts,
  input  nocArbPkg::portMaskT  enableMask,
  output nocArbPkg::portMaskT  grant
);

  import nocArbPkg::*;

  arbStateT state;
  arbStateT stateNext;
  portMaskT reqVec;
  portMaskT effReq;
  portMaskT grantVec;
  portMaskT holdMask;
  portMaskT rrPick;
  portMaskT runTimer;
  portMaskT timesUp;
  logic     holdGrant;
  int       holderIdx;

  // Scan starts after lastIdx and reaches lastIdx itself only at the end
  function automatic portMaskT pickNext(input portMaskT reqs, input int lastIdx);
    portMaskT pick;
    int       idx;
    pick = '0;
    for (int off = 1; off <= `NOC_NUM_PORTS; off++)
    begin
      idx = (lastIdx + off) % `NOC_NUM_PORTS;
      if (reqs[idx] && (pick == '0))
      begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  always_comb
  begin
    for (int i = 0; i < `NOC_NUM_PORTS; i++)
    begin
      reqVec[i] = inPorts[i].req;
    end
  end

  // Disabled ports never compete
  assign effReq = reqVec & enableMask;

  assign grantVec = state[`NOC_NUM_PORTS:1];
  assign grant    = grantVec;

  // IDLE behaves as if South held last, so the scan gives Local first
  always_comb
  begin
    case (state)
      GRANT_L: holderIdx = 0;
      GRANT_N: holderIdx = 1;
      GRANT_E: holderIdx = 2;
      GRANT_W: holderIdx = 3;
      GRANT_S: holderIdx = 4;
      default: holderIdx = `NOC_NUM_PORTS - 1;
    endcase
  end

  // Holder keeps the output while it requests and its timer has time left
  assign holdMask  = grantVec & effReq & ~timesUp;
  assign holdGrant = |holdMask;
  assign runTimer  = holdGrant ? grantVec : '0;

  assign rrPick = pickNext(effReq, holderIdx);

  always_comb
  begin
    if (holdGrant)
    begin
      stateNext = state;
    end
    else if (rrPick != '0)
    begin
      stateNext = arbStateT'({rrPick, 1'b0});
    end
    else
    begin
      stateNext = IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= stateNext;
    end
  end

  for (genvar p = 0; p < `NOC_NUM_PORTS; p++)
  begin : gTimer
    packetTimer i_timer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (inPorts[p].flitId),
      .length   (inPorts[p].length),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

endmodule

/* hdl/outputFlitMux.sv */
`include "noc_consts.svh"

module outputFlitMux (
  input  nocArbPkg::portMaskT  grant,
  input  nocArbPkg::portInArrT inPorts,
  output nocArbPkg::outFlitT   outFlit
);

  import nocArbPkg::*;

  flitDataT dataSel;
  logic     validSel;

  // Grant is one-hot, so AND-OR picks exactly one port
  always_comb
  begin
    dataSel  = '0;
    validSel = 1'b0;
    for (int i = 0; i < `NOC_NUM_PORTS; i++)
    begin
      dataSel  = dataSel | ({`NOC_DATA_W{grant[i]}} & inPorts[i].data);
      // Grant stays one cycle after a dropped req
      validSel = validSel | (grant[i] & inPorts[i].req);
    end
  end

  assign outFlit.valid = validSel;
  assign outFlit.data  = dataSel;

endmodule

/* hdl/packetTimer.sv */
`include "noc_consts.svh"

module packetTimer (
  input  logic              clk,
  input  logic              rst,
  input  nocArbPkg::flitIdT flitId,
  input  nocArbPkg::lengthT length,
  input  logic              runTimer,
  output logic              timesUp
);

  import nocArbPkg::*;

  lengthT limit;
  lengthT count;

  // Header flits refresh the limit even while another port owns the output
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flitId == flitIdT'(`NOC_HEAD_ID))
    begin
      limit <= length;
    end
  end

  // Count only while the port holds the grant, restart from zero otherwise
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (runTimer)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  // Grant lasts limit+1 cycles, count starts at zero on the first one
  assign timesUp = (count == limit);

endmodule

/* hdl/portEnableRegs.sv */
module portEnableRegs (
  input  logic                clk,
  input  logic                rst,
  input  logic                cfgWrite,
  input  nocArbPkg::portMaskT cfgEnable,
  output nocArbPkg::portMaskT enableMask
);

  import nocArbPkg::*;

  localparam portMaskT AllEnabled = '1;

  portMaskT maskReg;

  // All ports compete for the output out of reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      maskReg <= AllEnabled;
    end
    else if (cfgWrite)
    begin
      maskReg <= cfgEnable;
    end
  end

  // New mask is seen by the arbiter from the edge after the strobe
  assign enableMask = maskReg;

endmodule

/* hdl/routerOutputPort.sv */
module routerOutputPort (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cfgWrite,
  input  nocArbPkg::portMaskT  cfgEnable,
  input  nocArbPkg::portInArrT inPorts,
  output nocArbPkg::portMaskT  grant,
  output nocArbPkg::outFlitT   outFlit
);

  import nocArbPkg::*;

  portMaskT enableMask;

  portEnableRegs i_enableRegs (
    .clk        (clk),
    .rst        (rst),
    .cfgWrite   (cfgWrite),
    .cfgEnable  (cfgEnable),
    .enableMask (enableMask)
  );

  outputArbiter i_arbiter (
    .clk        (clk),
    .rst        (rst),
    .inPorts    (inPorts),
    .enableMask (enableMask),
    .grant      (grant)
  );

  // Output flit follows the registered grant with no extra delay
  outputFlitMux i_flitMux (
    .grant   (grant),
    .inPorts (inPorts),
    .outFlit (outFlit)
  );

endmodule

/* src.f */
+incdir+hdl
hdl/nocArbPkg.sv
hdl/packetTimer.sv
hdl/portEnableRegs.sv
hdl/outputArbiter.sv
hdl/outputFlitMux.sv
hdl/routerOutputPort.sv
verif/routerOutputPort_properties.sv
verif/tbRouterOutputPort.sv

/* verif/arb_vectors.txt */
# tag cfgWrite cfgEnable req | flitId LNEWS | length LNEWS | data LNEWS | expected grant valid data
# cfgEnable, req and grant are hex masks with bit 0 = Local, then North, East, West, South
reset 0 1f 00 0 0 0 0 0 000 000 000 000 000 a000 b001 c002 d003 e004 00 0 0000
prio  0 1f 16 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 00 0 0000
prio  0 1f 16 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
prio  0 1f 16 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
prio  0 1f 00 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 04 0 c002
prio  0 1f 00 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 00 0 0000
hold  0 1f 05 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 00 0 0000
hold  0 1f 05 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 01 1 a000
hold  0 1f 05 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 01 1 a000
hold  0 1f 05 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 01 1 a000
hold  0 1f 05 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 01 1 a000
hold  0 1f 04 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 04 1 c002
hold  0 1f 00 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 04 0 c002
hold  0 1f 00 1 1 1 1 1 003 000 000 000 000 a000 b001 c002 d003 e004 00 0 0000
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 00 0 0000
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 01 1 a000
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 04 1 c002
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 08 1 d003
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 10 1 e004
rr    0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 01 1 a000
rr    0 1f 1d 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 0 b001
rr    0 1f 00 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 04 0 c002
rr    0 1f 00 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 00 0 0000
mask  1 1b 00 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 00 0 0000
mask  0 1b 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 00 0 0000
mask  0 1b 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 01 1 a000
mask  0 1b 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
mask  0 1b 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
mask  0 1b 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 08 1 d003
mask  1 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 10 1 e004
mask  0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 01 1 a000
mask  0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
mask  0 1f 1f 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 02 1 b001
mask  0 1f 00 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 04 0 c002
mask  0 1f 00 1 1 1 1 1 000 001 000 000 000 a000 b001 c002 d003 e004 00 0 0000

/* verif/routerOutputPort_properties.sv */
module routerOutputPortProperties (
  input logic                clk,
  input logic                rst,
  input nocArbPkg::portMaskT enableMask,
  input nocArbPkg::portMaskT grant,
  input nocArbPkg::outFlitT  outFlit
);

  timeunit 1ns;
  timeprecision 1ps;

  // At most one port owns the output
  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is not one-hot: %b", grant);

  assert property (@(posedge clk) disable iff (rst) outFlit.valid |-> grant != '0)
    else $error("outFlit.valid high with no grant");

  // Reset leaves the grant clear on the following cycle
  assert property (@(posedge clk) rst |=> grant == '0)
    else $error("grant not cleared after reset: %b", grant);

  // A grant bit only rises for a port enabled when the decision was taken
  assert property (@(posedge clk) disable iff (rst)
    (grant & ~$past(grant) & ~$past(enableMask)) == '0)
    else $error("grant %b rose for a disabled port", grant);

endmodule

bind routerOutputPort routerOutputPortProperties i_props (
  .clk        (clk),
  .rst        (rst),
  .enableMask (enableMask),
  .grant      (grant),
  .outFlit    (outFlit)
);

/* verif/tbRouterOutputPort.sv */
`include "noc_consts.svh"

module tbRouterOutputPort;

  timeunit 1ns;
  timeprecision 1ps;

  import nocArbPkg::*;

  localparam int ClkPeriod     = 20;
  localparam int TimeoutMargin = 20;
  localparam int NumFields     = 21;

  typedef struct packed
  {
    logic [63:0] tag;
    logic        cfgWrite;
    portMaskT    cfgEnable;
    portInArrT   inPorts;
    portMaskT    expGrant;
    logic        expValid;
    flitDataT    expData;
  } vectorT;

  logic      clk = 1'b0;
  logic      rst;
  logic      cfgWrite;
  portMaskT  cfgEnable;
  portInArrT inPorts;
  portMaskT  grant;
  outFlitT   outFlit;

  vectorT vectors[$];
  int     cycleCount = 0;
  int     cycleLimit = 0;

  routerOutputPort i_dut (
    .clk       (clk),
    .rst       (rst),
    .cfgWrite  (cfgWrite),
    .cfgEnable (cfgEnable),
    .inPorts   (inPorts),
    .grant     (grant),
    .outFlit   (outFlit)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
    begin
      $display("Timeout: vectors still running after %0d cycles", cycleLimit);
      $display("Test FAILED");
      $fatal(1, "run did not finish in time");
    end
  end

  task automatic failRun(input string reason);
    $display("%0s", reason);
    $display("Test FAILED");
    $fatal(1, "%0s", reason);
  endtask

  task automatic checkValue(input logic [63:0] tag, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %0s %0s: expected %h, actual %h", tag, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "mismatch on %0s", what);
    end
  endtask

  task automatic loadVectors();
    int          fd;
    int          n;
    int          lineNo;
    string       line;
    logic [63:0] tag;
    logic [31:0] f [NumFields];
    vectorT      v;
    lineNo = 0;
    fd = $fopen("verif/arb_vectors.txt", "r");
    if (fd == 0)
      failRun("Could not open verif/arb_vectors.txt");
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      lineNo++;
      if (n < 2 || line.substr(0, 0) == "#")
        continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  tag, f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                  f[7], f[8], f[9], f[10], f[11], f[12], f[13],
                  f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
      if (n != NumFields + 1)
        failRun($sformatf("Vector file line %0d has the wrong number of fields", lineNo));
      v.tag       = tag;
      v.cfgWrite  = f[0][0];
      v.cfgEnable = f[1][`NOC_NUM_PORTS-1:0];
      for (int p = 0; p < `NOC_NUM_PORTS; p++)
      begin
        v.inPorts[p].req    = f[2][p];
        v.inPorts[p].flitId = f[3 + p][`NOC_FLIT_ID_W-1:0];
        v.inPorts[p].length = f[8 + p][`NOC_LENGTH_W-1:0];
        v.inPorts[p].data   = f[13 + p][`NOC_DATA_W-1:0];
      end
      v.expGrant = f[18][`NOC_NUM_PORTS-1:0];
      v.expValid = f[19][0];
      v.expData  = f[20][`NOC_DATA_W-1:0];
      vectors.push_back(v);
    end
    $fclose(fd);
    if (vectors.size() == 0)
      failRun("Vector file holds no vectors");
  endtask

  task automatic applyVector(input vectorT v);
    @(posedge clk);
    cfgWrite  <= v.cfgWrite;
    cfgEnable <= v.cfgEnable;
    inPorts   <= v.inPorts;
    // Outputs have long settled here, just ahead of the next edge
    #(ClkPeriod - 2);
    checkValue(v.tag, "grant", 32'(v.expGrant), 32'(grant));
    checkValue(v.tag, "valid", 32'(v.expValid), 32'(outFlit.valid));
    checkValue(v.tag, "data", 32'(v.expData), 32'(outFlit.data));
  endtask

  initial
  begin
    rst       = 1'b1;
    cfgWrite  = 1'b0;
    cfgEnable = '1;
    inPorts   = '0;
    loadVectors();
    cycleLimit = vectors.size() + TimeoutMargin;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    foreach (vectors[i])
    begin
      applyVector(vectors[i]);
    end
    $display("Test OK");
    $finish;
  end

endmodule
